/* verilog/actuator_pkg.sv */
// Types and timing shared by the actuator safety stage
// All limits are in clock cycles and sized for short simulation runs
// Every limit must fit in TIMER_W bits
`default_nettype none

package actuator_pkg;

    // ==============================
    // Timing limits
    // ==============================
    localparam int TIMER_W            = 8;   // Width of run and settle counters
    localparam int GRINDER_MAX_CYCLES = 40;  // Both grinders
    localparam int WATER_MAX_CYCLES   = 80;  // Pour-over and direct valve
    localparam int PAPER_MAX_CYCLES   = 12;
    localparam int SETTLE_CYCLES      = 5;   // Block after any non-heater change

    // ==============================
    // Status widths
    // ==============================
    localparam int COUNT_W = 3;  // Holds 0..6
    localparam int NUM_ACT = 6;  // Channels in actuator_vec_t

    // Bit position of each channel in actuator_vec_t
    // Heater sits on top, so the gated five form bits 4..0
    typedef enum logic [2:0] {
        ACT_PAPER_MOTOR  = 3'd0,
        ACT_GRINDER1     = 3'd1,
        ACT_GRINDER0     = 3'd2,
        ACT_WATER_DIRECT = 3'd3,
        ACT_WATER_POUR   = 3'd4,
        ACT_HEATER       = 3'd5
    } actuator_e;

    // One bit per actuator, first member is the MSB
    typedef struct packed {
        logic heater;
        logic water_pour;
        logic water_direct;
        logic grinder0;
        logic grinder1;
        logic paper_motor;
    } actuator_vec_t;

    // Plant safety inputs, all plain levels
    typedef struct packed {
        logic temp_ready;            // Water at brew temperature
        logic pressure_ready;        // Pump pressure in range
        logic paper_filter_present;
        logic system_fault;          // Kills every actuator
        logic emergency_stop;        // Kills every actuator
    } plant_status_t;

endpackage

`default_nettype wire

/* verilog/run_timer.sv */
// Maximum on-time guard for one actuator
// MAX_CYCLES must fit in the package counter width
`timescale 1ns/10ps
`default_nettype none

module run_timer #(
    parameter int MAX_CYCLES = 40  // On-time limit in cycles
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  run,      // Raw command level for this channel
    output logic timeout   // Limit exceeded and held while run stays high
);

    localparam int            TW    = actuator_pkg::TIMER_W;
    localparam logic [TW-1:0] LIMIT = TW'(MAX_CYCLES);

    logic [TW-1:0] cnt;  // Consecutive cycles with run high

    // ==============================
    // On-time counter
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            timeout <= 1'b0;
        end else if (!run) begin
            // Command dropped so the window starts over
            cnt     <= '0;
            timeout <= 1'b0;
        end else if (cnt == LIMIT) begin
            timeout <= 1'b1;       // One edge after the limit is reached
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Counter parks at the limit and never runs past it
    a_cnt_bound : assert property (
        @(posedge clk) disable iff (!rst_n)
        cnt <= LIMIT
    ) else $error("run_timer counter above limit %0d", MAX_CYCLES);

endmodule

`default_nettype wire

/* verilog/settle_timer.sv */
// Settling block for the five non-heater actuators
// Any toggle of their permitted bits reloads the delay
// Heater changes are ignored here
`timescale 1ns/10ps
`default_nettype none

module settle_timer (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire actuator_pkg::actuator_vec_t permit,  // Gate output from this cycle
    output logic                        settle_active     // Blocks the gated five
);

    localparam int TW  = actuator_pkg::TIMER_W;
    localparam int TOP = actuator_pkg::ACT_WATER_POUR;  // Highest non-heater bit

    logic [TOP:0]  cur;      // Non-heater bits this cycle
    logic [TOP:0]  prev;     // Same bits one edge ago
    logic [TW-1:0] cnt;      // Remaining settle cycles
    logic          changed;

    assign cur     = permit[TOP:0];
    assign changed = (cur != prev);

    // ==============================
    // Change detect and drain
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev          <= '0;
            cnt           <= '0;
            settle_active <= 1'b0;
        end else begin
            prev <= cur;
            if (changed) begin
                cnt           <= TW'(actuator_pkg::SETTLE_CYCLES);  // Restart delay
                settle_active <= 1'b1;
            end else if (cnt != '0) begin
                cnt           <= cnt - 1'b1;
                settle_active <= 1'b1;
            end else begin
                settle_active <= 1'b0;    // Drained
            end
        end
    end

    a_cnt_bound : assert property (
        @(posedge clk) disable iff (!rst_n)
        cnt <= TW'(actuator_pkg::SETTLE_CYCLES)
    ) else $error("settle_timer counter above settle delay");

endmodule

`default_nettype wire

/* verilog/safety_gate.sv */
// Combinational permission for all six actuators
// Fault and e-stop override every command
// clk only samples the checks below, permit has no register here
`timescale 1ns/10ps
`default_nettype none

module safety_gate (
    input  wire                          clk,
    input  wire actuator_pkg::actuator_vec_t  cmd,      // Recipe commands
    input  wire actuator_pkg::plant_status_t  plant,
    input  wire actuator_pkg::actuator_vec_t  timeout,  // Heater bit unused
    input  wire                          settle_active,
    output actuator_pkg::actuator_vec_t       permit
);

    logic kill;     // Fault or e-stop
    logic run_ok;   // Gated five may run at all

    assign kill   = plant.system_fault | plant.emergency_stop;
    assign run_ok = ~kill & ~settle_active;

    // ==============================
    // Per-channel rules
    // ==============================
    always_comb begin
        permit = '0;

        // Heater has no run limit and no settle block
        permit.heater = cmd.heater & ~kill;

        // Pour-over needs hot water, pressure and a filter
        permit.water_pour = cmd.water_pour & run_ok & ~timeout.water_pour
                          & plant.temp_ready
                          & plant.pressure_ready
                          & plant.paper_filter_present;

        // Direct water only cares about pressure
        permit.water_direct = cmd.water_direct & run_ok & ~timeout.water_direct
                            & plant.pressure_ready;

        permit.grinder0 = cmd.grinder0 & run_ok & ~timeout.grinder0;
        permit.grinder1 = cmd.grinder1 & run_ok & ~timeout.grinder1;

        // No filter means nothing to feed
        permit.paper_motor = cmd.paper_motor & run_ok & ~timeout.paper_motor
                           & plant.paper_filter_present;
    end

    // ==============================
    // Safety checks
    // ==============================
    a_kill_all : assert property (
        @(posedge clk)
        (plant.system_fault || plant.emergency_stop) |-> permit == '0
    ) else $error("permit set during fault or e-stop");

    a_pour_ready : assert property (
        @(posedge clk)
        permit.water_pour |-> plant.temp_ready && plant.pressure_ready
    ) else $error("water_pour permitted without temp and pressure");

endmodule

`default_nettype wire

/* verilog/actuator_status.sv */
// Output register for the actuator drives plus live status
// Count and flag follow act without extra delay
`timescale 1ns/10ps
`default_nettype none

module actuator_status (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire actuator_pkg::actuator_vec_t   permit,
    output actuator_pkg::actuator_vec_t        act,          // Registered drives
    output logic [actuator_pkg::COUNT_W-1:0]   active_count,
    output logic                               actuators_active
);

    localparam int CW = actuator_pkg::COUNT_W;

    logic [actuator_pkg::NUM_ACT-1:0] on_bits;  // act as a flat vector

    // One edge from permit to the pins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act <= '0;
        end else begin
            act <= permit;
        end
    end

    assign on_bits = act;

    // ==============================
    // Population count
    // ==============================
    always_comb begin
        active_count = '0;
        for (int i = 0; i < actuator_pkg::NUM_ACT; i++) begin
            active_count = active_count + CW'(on_bits[i]);
        end
    end

    assign actuators_active = (active_count != '0);  // Any drive on

    a_active_flag : assert property (
        @(posedge clk) disable iff (!rst_n)
        actuators_active == (act != '0)
    ) else $error("actuators_active disagrees with act");

endmodule

`default_nettype wire

/* verilog/actuator_control.sv */
// Actuator safety stage top level
// Inputs are plain levels, act follows them after one edge
// Heater has no run timer, its timeout bit is tied low
`timescale 1ns/10ps
`default_nettype none

module actuator_control (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire actuator_pkg::actuator_vec_t   cmd,     // From recipe engine
    input  wire actuator_pkg::plant_status_t   plant,
    output actuator_pkg::actuator_vec_t        act,     // Registered drives
    output logic [actuator_pkg::COUNT_W-1:0]   active_count,
    output logic                               actuators_active
);

    wire actuator_pkg::actuator_vec_t timeout;   // One bit per run timer
    actuator_pkg::actuator_vec_t      permit;    // Gate result, same cycle
    logic                             settle_active;

    assign timeout.heater = 1'b0;  // Heater may run indefinitely

    // ==============================
    // Permission
    // ==============================
    safety_gate i_safety_gate (
        .clk           (clk),
        .cmd           (cmd),
        .plant         (plant),
        .timeout       (timeout),
        .settle_active (settle_active),
        .permit        (permit)
    );

    // ==============================
    // Run-time limits
    // ==============================
    run_timer #(.MAX_CYCLES(actuator_pkg::WATER_MAX_CYCLES)) i_run_water_pour (
        .clk(clk), .rst_n(rst_n), .run(cmd.water_pour), .timeout(timeout.water_pour)
    );

    run_timer #(.MAX_CYCLES(actuator_pkg::WATER_MAX_CYCLES)) i_run_water_direct (
        .clk(clk), .rst_n(rst_n), .run(cmd.water_direct), .timeout(timeout.water_direct)
    );

    run_timer #(.MAX_CYCLES(actuator_pkg::GRINDER_MAX_CYCLES)) i_run_grinder0 (
        .clk(clk), .rst_n(rst_n), .run(cmd.grinder0), .timeout(timeout.grinder0)
    );

    run_timer #(.MAX_CYCLES(actuator_pkg::GRINDER_MAX_CYCLES)) i_run_grinder1 (
        .clk(clk), .rst_n(rst_n), .run(cmd.grinder1), .timeout(timeout.grinder1)
    );

    run_timer #(.MAX_CYCLES(actuator_pkg::PAPER_MAX_CYCLES)) i_run_paper_motor (
        .clk(clk), .rst_n(rst_n), .run(cmd.paper_motor), .timeout(timeout.paper_motor)
    );

    // Settling block fed back into the gate
    settle_timer i_settle_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .permit        (permit),
        .settle_active (settle_active)
    );

    actuator_status i_actuator_status (
        .clk              (clk),
        .rst_n            (rst_n),
        .permit           (permit),
        .act              (act),
        .active_count     (active_count),
        .actuators_active (actuators_active)
    );

endmodule

`default_nettype wire

/* tests/tb_actuator_control.sv */
// Random and directed testbench for the actuator safety stage
// Inputs change on the falling edge and outputs are compared at the next falling edge
// against a cycle model kept here
`timescale 1ns/10ps
`default_nettype none

module tb_actuator_control;

    localparam logic [31:0] SEED  = 32'h9aaff39f;
    localparam int RESET_CYCLES    = 4;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int COUNT_CYCLES    = 300;
    localparam int DIRECTED_CYCLES = 300;     // Upper bound for tests 3 to 5
    localparam int CYCLE_LIMIT     = RESET_CYCLES + RANDOM_CYCLES + COUNT_CYCLES
                                   + DIRECTED_CYCLES + 200;
    localparam logic [5:0] GATED   = 6'b011111;  // Non-heater channels

    logic                              clk;
    logic                              rst_n;
    actuator_pkg::actuator_vec_t       cmd;
    actuator_pkg::plant_status_t       plant;
    actuator_pkg::actuator_vec_t       act;
    logic [actuator_pkg::COUNT_W-1:0]  active_count;
    logic                              actuators_active;

    // Model state indexed by bit position in actuator_vec_t
    actuator_pkg::actuator_vec_t m_act;
    int          m_run_cnt [5];
    logic [4:0]  m_timeout;
    logic [4:0]  m_prev;        // Permitted non-heater bits one edge ago
    int          m_settle_cnt;
    logic        m_settle;

    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          test_start_errors;
    int          cycle_count;

    actuator_control i_actuator_control (
        .clk              (clk),
        .rst_n            (rst_n),
        .cmd              (cmd),
        .plant            (plant),
        .act              (act),
        .active_count     (active_count),
        .actuators_active (actuators_active)
    );

    always #5 clk = ~clk;  // 10 ns period

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int ones_in(input logic [5:0] v);
        int n;
        n = 0;
        for (int b = 0; b < 6; b++) begin
            n += int'(v[b]);
        end
        return n;
    endfunction

    // On-time limit per gated channel
    function automatic int run_limit(input int ch);
        if (ch == int'(actuator_pkg::ACT_PAPER_MOTOR)) return actuator_pkg::PAPER_MAX_CYCLES;
        if (ch >= int'(actuator_pkg::ACT_WATER_DIRECT)) return actuator_pkg::WATER_MAX_CYCLES;
        return actuator_pkg::GRINDER_MAX_CYCLES;   // Both grinders
    endfunction

    function automatic actuator_pkg::plant_status_t plant_ok();
        actuator_pkg::plant_status_t p;
        p = '0;
        p.temp_ready           = 1'b1;
        p.pressure_ready       = 1'b1;
        p.paper_filter_present = 1'b1;
        return p;
    endfunction

    // ==============================
    // Cycle model
    // ==============================
    function automatic actuator_pkg::actuator_vec_t gate_model(
        input actuator_pkg::actuator_vec_t c,
        input actuator_pkg::plant_status_t p,
        input logic [4:0]                  to,
        input logic                        blocked
    );
        actuator_pkg::actuator_vec_t g;
        logic safe;
        logic free;
        safe = !p.system_fault && !p.emergency_stop;
        free = safe && !blocked;
        g.heater       = c.heater && safe;              // No limit and no block
        g.water_pour   = c.water_pour && free && !to[actuator_pkg::ACT_WATER_POUR]
                         && p.temp_ready && p.pressure_ready && p.paper_filter_present;
        g.water_direct = c.water_direct && free && !to[actuator_pkg::ACT_WATER_DIRECT]
                         && p.pressure_ready;
        g.grinder0     = c.grinder0 && free && !to[actuator_pkg::ACT_GRINDER0];
        g.grinder1     = c.grinder1 && free && !to[actuator_pkg::ACT_GRINDER1];
        g.paper_motor  = c.paper_motor && free && !to[actuator_pkg::ACT_PAPER_MOTOR]
                         && p.paper_filter_present;
        return g;
    endfunction

    task automatic model_reset();
        for (int ch = 0; ch < 5; ch++) begin
            m_run_cnt[ch] = 0;
        end
        m_timeout    = '0;
        m_prev       = '0;
        m_settle_cnt = 0;
        m_settle     = 1'b0;
        m_act        = '0;
    endtask

    // One rising edge with c and p sampled
    task automatic model_edge(input actuator_pkg::actuator_vec_t c,
                              input actuator_pkg::plant_status_t p);
        logic [5:0] perm;
        logic [5:0] cb;
        perm = gate_model(c, p, m_timeout, m_settle);
        cb   = c;
        for (int ch = 0; ch < 5; ch++) begin
            if (!cb[ch]) begin
                m_run_cnt[ch] = 0;
                m_timeout[ch] = 1'b0;
            end else if (m_run_cnt[ch] == run_limit(ch)) begin
                m_timeout[ch] = 1'b1;                 // Flag one edge after limit
            end else begin
                m_run_cnt[ch] = m_run_cnt[ch] + 1;
            end
        end
        if (perm[4:0] != m_prev) begin
            m_settle_cnt = actuator_pkg::SETTLE_CYCLES;  // Reload on any toggle
            m_settle     = 1'b1;
        end else if (m_settle_cnt != 0) begin
            m_settle_cnt = m_settle_cnt - 1;
            m_settle     = 1'b1;
        end else begin
            m_settle = 1'b0;
        end
        m_prev = perm[4:0];
        m_act  = perm;
    endtask

    // ==============================
    // Drive and compare
    // ==============================
    task automatic check_outputs();
        int ones;
        ones   = ones_in(m_act);
        checks = checks + 1;
        assert (act == m_act) else begin
            errors++;
            $display("[FAIL] %0t act got %b expected %b", $time, act, m_act);
        end
        assert (int'(active_count) == ones) else begin
            errors++;
            $display("[FAIL] %0t active_count got %0d expected %0d",
                     $time, active_count, ones);
        end
        assert (actuators_active == (ones != 0)) else begin
            errors++;
            $display("[FAIL] %0t actuators_active got %b expected %b",
                     $time, actuators_active, (ones != 0));
        end
    endtask

    // Called at a falling edge and returns at the next one after the check
    task automatic apply(input actuator_pkg::actuator_vec_t c,
                         input actuator_pkg::plant_status_t p);
        cmd   = c;
        plant = p;
        model_edge(c, p);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic idle(input int n);
        repeat (n) apply('0, plant_ok());  // Clears timers and drains settling
    endtask

    task automatic report_test(input string name);
        $display("test %-12s : %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // ==============================
    // Timeout watchdog
    // ==============================
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    // ==============================
    // Tests
    // ==============================
    initial begin
        actuator_pkg::actuator_vec_t c;
        actuator_pkg::plant_status_t p;
        logic [31:0]                 r;
        int                          n;
        clk = 1'b0;
        rst_n = 1'b0;
        cmd = '0;
        plant = '0;
        rng_state = SEED;
        errors = 0;
        checks = 0;
        test_start_errors = 0;
        model_reset();

        // Test 1 checks the reset values
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_outputs();
        end
        rst_n = 1'b1;
        idle(3);
        report_test("reset");

        // Test 2 is random gating with fault and e-stop about 1 in 64
        c = '0;
        repeat (RANDOM_CYCLES) begin
            r = next_rand();
            for (int b = 0; b < 6; b++) begin
                if (r[4*b +: 4] == 4'd0) c = c ^ (6'b1 << b);  // Flip 1 in 16
            end
            r = next_rand();
            p.temp_ready           = r[0] | r[1];
            p.pressure_ready       = r[2] | r[3];
            p.paper_filter_present = r[4] | r[5];
            p.system_fault         = (r[11:6] == 6'd0);
            p.emergency_stop       = (r[17:12] == 6'd0);
            apply(c, p);
        end
        report_test("random");

        // Test 3 applies e-stop then fault with every command high
        for (int pass = 0; pass < 2; pass++) begin
            idle(12);
            c = '1;
            repeat (3) apply(c, plant_ok());
            p = plant_ok();
            if (pass == 0) p.emergency_stop = 1'b1;
            else           p.system_fault   = 1'b1;
            apply(c, p);
            assert (act == '0) else begin
                errors++;
                $display("[FAIL] %0t act %b not cleared by kill input", $time, act);
            end
            repeat (2) apply(c, p);
            apply(c, plant_ok());
            assert (act.heater) else begin
                errors++;
                $display("[FAIL] %0t heater not back one edge after release", $time);
            end
            n = 0;
            while ((act & GATED) == '0 && n < 20) begin
                apply(c, plant_ok());
                n++;
            end
            assert ((act & GATED) != '0) else begin
                errors++;
                $display("Gated actuators never came back after kill release");
            end
        end
        report_test("kill");

        // Test 4 holds the paper motor past its run-time limit
        idle(12);
        c = '0;
        c.paper_motor = 1'b1;
        for (int e = 1; e <= actuator_pkg::PAPER_MAX_CYCLES + 12; e++) begin
            apply(c, plant_ok());
            if (e == 1) begin
                assert (act.paper_motor) else begin
                    errors++;
                    $display("[FAIL] %0t paper_motor did not start", $time);
                end
            end
            if (e >= actuator_pkg::PAPER_MAX_CYCLES + 2) begin
                assert (!act.paper_motor) else begin
                    errors++;
                    $display("[FAIL] %0t paper_motor on past its limit", $time);
                end
            end
        end
        idle(3);                                  // Drop clears the timer
        n = 0;
        do begin
            apply(c, plant_ok());
            n++;
        end while (!act.paper_motor && n < 20);
        assert (act.paper_motor) else begin
            errors++;
            $display("Paper motor did not restart after its command was dropped");
        end
        report_test("run_limit");

        // Test 5 checks settling after a grinder 0 toggle and none after a heater toggle
        idle(12);
        c = '0;
        c.grinder0 = 1'b1;
        apply(c, plant_ok());
        c.grinder0 = 1'b0;
        c.grinder1 = 1'b1;
        for (int e = 1; e <= actuator_pkg::SETTLE_CYCLES + 1; e++) begin
            apply(c, plant_ok());
            assert (!act.grinder1) else begin
                errors++;
                $display("[FAIL] %0t grinder1 passed during settling", $time);
            end
        end
        n = 0;
        while (!act.grinder1 && n < 20) begin
            apply(c, plant_ok());
            n++;
        end
        assert (act.grinder1) else begin
            errors++;
            $display("Grinder 1 never appeared after settling");
        end
        idle(12);
        c = '0;
        c.heater = 1'b1;
        apply(c, plant_ok());
        c.heater   = 1'b0;
        c.grinder0 = 1'b1;
        apply(c, plant_ok());
        assert (act.grinder0) else begin
            errors++;
            $display("[FAIL] %0t heater toggle blocked grinder0", $time);
        end
        report_test("settle");

        // Test 6 checks the count with a healthy plant and many channels on
        c = '0;
        repeat (COUNT_CYCLES) begin
            r = next_rand();
            for (int b = 0; b < 6; b++) begin
                if (r[2*b +: 2] == 2'd0) c = c ^ (6'b1 << b);
            end
            apply(c, plant_ok());
        end
        report_test("count");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
verilog/actuator_pkg.sv
verilog/run_timer.sv
verilog/settle_timer.sv
verilog/safety_gate.sv
verilog/actuator_status.sv
verilog/actuator_control.sv
tests/tb_actuator_control.sv

/* Makefile */
# Verilator simulation of the actuator safety stage
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_actuator_control
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench, result taken from $(LOG)"
	@echo "  clean  remove build output and log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
